//--- list.f
+incdir+dv
logic/llc_hit_miss_pkg.sv
logic/llc_tag_store.sv
logic/llc_lookup_stage.sv
logic/llc_route_stage.sv
logic/llc_lock_box.sv
logic/llc_hit_miss_top.sv
dv/tb_llc_hit_miss.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the LLC hit/miss testbench with Verilator.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_llc_hit_miss \
  && ./obj_dir/Vtb_llc_hit_miss 2>&1 | tee sim.log \
  && ! grep -q "Simulation finished: FAIL" sim.log \
  && grep -q "Simulation finished: PASS" sim.log \
  || { echo "simulation run failed"; exit 1; }
echo "simulation run passed"

//--- dv/llc_ref_model.svh
// Reference model of the LLC tag lookup, included inside the testbench.
// Keeps its own tag, valid, dirty and round-robin state and predicts the
// result of every accepted descriptor, in acceptance order.

`ifndef LLC_REF_MODEL_SVH
`define LLC_REF_MODEL_SVH

// one expected output descriptor
typedef struct packed {
  int                         seq;
  llc_hit_miss_pkg::id_t      id;
  llc_hit_miss_pkg::addr_t    addr;
  logic                       write;
  logic                       hit;
  llc_hit_miss_pkg::way_ind_t way;
  logic                       evict;
  llc_hit_miss_pkg::tag_t     evict_tag;
} exp_entry_t;

llc_hit_miss_pkg::tag_t m_tag   [llc_hit_miss_pkg::NumSets][llc_hit_miss_pkg::NumWays];
logic                   m_valid [llc_hit_miss_pkg::NumSets][llc_hit_miss_pkg::NumWays];
logic                   m_dirty [llc_hit_miss_pkg::NumSets][llc_hit_miss_pkg::NumWays];
int                     m_rr    [llc_hit_miss_pkg::NumSets];

// state after the clear sweep
task automatic clear_model();
  for (int s = 0; s < llc_hit_miss_pkg::NumSets; s++) begin
    m_rr[s] = 0;
    for (int w = 0; w < llc_hit_miss_pkg::NumWays; w++) begin
      m_valid[s][w] = 1'b0;
      m_dirty[s][w] = 1'b0;
    end
  end
endtask

// lookup and update of one descriptor
function automatic exp_entry_t predict_lookup(input int seq, input llc_hit_miss_pkg::id_t id,
                                              input llc_hit_miss_pkg::addr_t addr,
                                              input logic write);
  exp_entry_t             e;
  int                     idx;
  int                     vict;
  llc_hit_miss_pkg::tag_t tag;
  idx         = int'(addr[9:6]);
  tag         = addr[31:10];
  vict        = -1;
  e.seq       = seq;
  e.id        = id;
  e.addr      = addr;
  e.write     = write;
  e.hit       = 1'b0;
  e.evict     = 1'b0;
  e.evict_tag = '0;
  for (int w = 0; w < llc_hit_miss_pkg::NumWays; w++) begin
    if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
      e.hit = 1'b1;
      vict  = w;
    end
  end
  if (e.hit) begin
    m_dirty[idx][vict] = m_dirty[idx][vict] | write;
  end else begin
    // first free way from way 0 up, else the round-robin way
    for (int w = llc_hit_miss_pkg::NumWays - 1; w >= 0; w--) begin
      if (!m_valid[idx][w]) begin
        vict = w;
      end
    end
    if (vict < 0) begin
      vict      = m_rr[idx];
      m_rr[idx] = (m_rr[idx] + 1) % llc_hit_miss_pkg::NumWays;
    end
    e.evict            = m_valid[idx][vict] && m_dirty[idx][vict];
    e.evict_tag        = m_tag[idx][vict];
    m_tag[idx][vict]   = tag;
    m_valid[idx][vict] = 1'b1;
    m_dirty[idx][vict] = write;
  end
  e.way = llc_hit_miss_pkg::way_ind_t'(1) << vict;
  return e;
endfunction

`endif

//--- dv/tb_llc_hit_miss.sv
// Testbench of the LLC hit/miss stage.
// Sends directed then random descriptors into a few colliding sets, answers
// every delivered line with a delayed unlock strobe and compares each output
// transfer with the reference model, in order.

`timescale 1ns/100ps

module tb_llc_hit_miss;

  localparam int NumDesc     = 300;
  localparam int NumDirected = 16;
  localparam int CycleLimit  = NumDesc * 20 + llc_hit_miss_pkg::NumSets + 8 + 40;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       valid_i;
  logic                       ready_o;
  llc_hit_miss_pkg::id_t      id_i;
  llc_hit_miss_pkg::addr_t    addr_i;
  logic                       write_i;
  logic                       unlock_valid_i;
  llc_hit_miss_pkg::index_t   unlock_index_i;
  llc_hit_miss_pkg::way_ind_t unlock_way_i;
  logic                       init_done_o;
  llc_hit_miss_pkg::id_t      desc_id_o;
  llc_hit_miss_pkg::addr_t    desc_addr_o;
  logic                       desc_write_o;
  llc_hit_miss_pkg::way_ind_t desc_way_o;
  logic                       desc_hit_o;
  logic                       desc_evict_o;
  llc_hit_miss_pkg::tag_t     desc_evict_tag_o;
  logic                       hit_valid_o;
  logic                       hit_ready_i;
  logic                       miss_valid_o;
  logic                       miss_ready_i;

  `include "llc_ref_model.svh"

  exp_entry_t                 exp_q [$];
  // lines delivered and not yet unlocked, and the unlocks still to send
  llc_hit_miss_pkg::index_t   lk_index [$];
  llc_hit_miss_pkg::way_ind_t lk_way [$];
  llc_hit_miss_pkg::index_t   pend_index [$];
  llc_hit_miss_pkg::way_ind_t pend_way [$];
  int                         pend_due [$];

  int          in_count     = 0;
  int          out_count    = 0;
  int          cur_idx      = 0;
  int          cycle_cnt    = 0;
  int          value_errors = 0;
  int          proto_errors = 0;
  logic [31:0] rng_state    = 32'd25;

  llc_hit_miss_top #(
    .LockEntries (4)
  ) uut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .valid_i          (valid_i),
    .ready_o          (ready_o),
    .id_i             (id_i),
    .addr_i           (addr_i),
    .write_i          (write_i),
    .unlock_valid_i   (unlock_valid_i),
    .unlock_index_i   (unlock_index_i),
    .unlock_way_i     (unlock_way_i),
    .init_done_o      (init_done_o),
    .desc_id_o        (desc_id_o),
    .desc_addr_o      (desc_addr_o),
    .desc_write_o     (desc_write_o),
    .desc_way_o       (desc_way_o),
    .desc_hit_o       (desc_hit_o),
    .desc_evict_o     (desc_evict_o),
    .desc_evict_tag_o (desc_evict_tag_o),
    .hit_valid_o      (hit_valid_o),
    .hit_ready_i      (hit_ready_i),
    .miss_valid_o     (miss_valid_o),
    .miss_ready_i     (miss_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // xorshift32 step
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // directed part fills set 5, hits all four ways with writes, then evicts them
  task automatic load_desc(input int seq);
    logic [31:0] r;
    r = next_random();
    if (seq < NumDirected) begin
      addr_i  = {22'((seq < 4) ? seq + 1 : seq - 3), 4'd5, 6'd0};
      write_i = (seq >= 4 && seq < 8) ? 1'b1 : seq[0];
    end else begin
      addr_i  = {22'(1 + (r >> 4) % 6), 4'(1 + r % 3), r[15:10]};
      write_i = r[20];
    end
    id_i = llc_hit_miss_pkg::id_t'(seq);
  endtask

  task automatic check_value(input string name, input int seq, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      value_errors++;
      $display("FAILED %s desc %0d: expected %h actual %h", name, seq, expected, actual);
    end
  endtask

  function automatic int find_locked(input llc_hit_miss_pkg::index_t idx,
                                     input llc_hit_miss_pkg::way_ind_t way);
    for (int i = 0; i < lk_index.size(); i++) begin
      if (lk_index[i] == idx && lk_way[i] == way) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic compare_output();
    exp_entry_t e;
    string      phase;
    int         pos;
    if (exp_q.size() == 0) begin
      proto_errors++;
      $display("output transfer with no descriptor outstanding");
      return;
    end
    e     = exp_q.pop_front();
    phase = (e.seq < NumDirected) ? "directed" : "random";
    check_value({phase, " id"}, e.seq, 32'(e.id), 32'(desc_id_o));
    check_value({phase, " addr"}, e.seq, e.addr, desc_addr_o);
    check_value({phase, " write"}, e.seq, 32'(e.write), 32'(desc_write_o));
    check_value({phase, " hit"}, e.seq, 32'(e.hit), 32'(desc_hit_o));
    check_value({phase, " port"}, e.seq, 32'(e.hit), 32'(hit_valid_o));
    check_value({phase, " way"}, e.seq, 32'(e.way), 32'(desc_way_o));
    check_value({phase, " evict"}, e.seq, 32'(e.evict), 32'(desc_evict_o));
    // victim tag only means something on a write back
    if (e.evict) begin
      check_value({phase, " evict tag"}, e.seq, 32'(e.evict_tag), 32'(desc_evict_tag_o));
    end
    pos = find_locked(desc_addr_o[9:6], desc_way_o);
    if (pos >= 0) begin
      proto_errors++;
      $display("desc %0d delivered while its line was still locked", e.seq);
    end
    lk_index.push_back(desc_addr_o[9:6]);
    lk_way.push_back(desc_way_o);
    pend_index.push_back(desc_addr_o[9:6]);
    pend_way.push_back(desc_way_o);
    pend_due.push_back(cycle_cnt + 1 + int'(next_random() % 8));
    out_count++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor sampled on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    int pos;
    cycle_cnt++;
    if (!init_done_o && (ready_o || hit_valid_o || miss_valid_o)) begin
      proto_errors++;
      $display("ready or output valid high before the clear sweep finished");
    end
    if (hit_valid_o && miss_valid_o) begin
      proto_errors++;
      $display("hit and miss valid high in the same cycle");
    end
    if (valid_i && ready_o) begin
      exp_q.push_back(predict_lookup(in_count, id_i, addr_i, write_i));
      in_count++;
    end
    if ((hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i)) begin
      compare_output();
    end
    // line is free again from this edge on
    if (unlock_valid_i) begin
      pos = find_locked(unlock_index_i, unlock_way_i);
      if (pos >= 0) begin
        lk_index.delete(pos);
        lk_way.delete(pos);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // drivers on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    logic [31:0] r;
    r              = next_random();
    hit_ready_i    = (r[1:0] != 2'b00);
    miss_ready_i   = (r[3:2] != 2'b00);
    unlock_valid_i = 1'b0;
    if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt) begin
      unlock_valid_i = 1'b1;
      unlock_index_i = pend_index.pop_front();
      unlock_way_i   = pend_way.pop_front();
      pend_due.delete(0);
    end
    // hold an offered descriptor until it is taken
    if (init_done_o && !(valid_i && in_count == cur_idx)) begin
      cur_idx = in_count;
      valid_i = 1'b0;
      if (cur_idx < NumDesc && r[5:4] != 2'b00) begin
        valid_i = 1'b1;
        load_desc(cur_idx);
      end
    end
  end

  initial begin
    while (cycle_cnt < CycleLimit) @(negedge clk_i);
    $display("timeout after %0d cycles, %0d of %0d descriptors delivered",
             cycle_cnt, out_count, NumDesc);
    $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int init_wait;
    rst_n_i        = 1'b0;
    valid_i        = 1'b0;
    id_i           = '0;
    addr_i         = '0;
    write_i        = 1'b0;
    hit_ready_i    = 1'b0;
    miss_ready_i   = 1'b0;
    unlock_valid_i = 1'b0;
    unlock_index_i = '0;
    unlock_way_i   = '0;
    clear_model();
    repeat (8) @(negedge clk_i);
    rst_n_i   = 1'b1;
    init_wait = 0;
    while (!init_done_o && init_wait < llc_hit_miss_pkg::NumSets + 2) begin
      @(negedge clk_i);
      init_wait++;
    end
    if (!init_done_o) begin
      proto_errors++;
      $display("init_done_o did not rise within %0d cycles of reset release",
               llc_hit_miss_pkg::NumSets + 2);
    end
    while (out_count < NumDesc) @(negedge clk_i);
    // any extra output shows up in this quiet tail
    repeat (20) @(negedge clk_i);
    if (out_count != in_count) begin
      proto_errors++;
      $display("%0d descriptors in but %0d out", in_count, out_count);
    end
    if (exp_q.size() != 0) begin
      proto_errors++;
      $display("%0d expected descriptors never delivered", exp_q.size());
    end
    $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- logic/llc_hit_miss_top.sv
// Top level of the LLC hit/miss stage.
// Descriptors pass the lookup stage and the route stage. The tag store is
// read and updated between them, and the lock box holds back lines that
// are still in use downstream.

`timescale 1ns/100ps

module llc_hit_miss_top #(
  parameter int unsigned LockEntries = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // input channel
  input  logic                       valid_i,
  output logic                       ready_o,
  input  llc_hit_miss_pkg::id_t      id_i,
  input  llc_hit_miss_pkg::addr_t    addr_i,
  input  logic                       write_i,
  // unlock strobe
  input  logic                       unlock_valid_i,
  input  llc_hit_miss_pkg::index_t   unlock_index_i,
  input  llc_hit_miss_pkg::way_ind_t unlock_way_i,
  output logic                       init_done_o,
  // output ports
  output llc_hit_miss_pkg::id_t      desc_id_o,
  output llc_hit_miss_pkg::addr_t    desc_addr_o,
  output logic                       desc_write_o,
  output llc_hit_miss_pkg::way_ind_t desc_way_o,
  output logic                       desc_hit_o,
  output logic                       desc_evict_o,
  output llc_hit_miss_pkg::tag_t     desc_evict_tag_o,
  output logic                       hit_valid_o,
  input  logic                       hit_ready_i,
  output logic                       miss_valid_o,
  input  logic                       miss_ready_i
);

  // lookup stage outputs
  logic                       s1_valid;
  llc_hit_miss_pkg::id_t      s1_id;
  llc_hit_miss_pkg::addr_t    s1_addr;
  logic                       s1_write;
  llc_hit_miss_pkg::index_t   s1_index;
  llc_hit_miss_pkg::tag_t     s1_tag;
  logic                       s2_accept;

  // tag store result
  logic                       lookup_hit;
  llc_hit_miss_pkg::way_ind_t lookup_way;
  logic                       lookup_evict;
  llc_hit_miss_pkg::tag_t     lookup_evict_tag;

  // lock box
  llc_hit_miss_pkg::index_t   query_index;
  llc_hit_miss_pkg::way_ind_t query_way;
  logic                       lock_req;
  logic                       locked;

  llc_lookup_stage u_lookup (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .id_i        (id_i),
    .addr_i      (addr_i),
    .write_i     (write_i),
    .init_done_i (init_done_o),
    .accept_i    (s2_accept),
    .ready_o     (ready_o),
    .valid_o     (s1_valid),
    .id_o        (s1_id),
    .addr_o      (s1_addr),
    .write_o     (s1_write),
    .index_o     (s1_index),
    .tag_o       (s1_tag)
  );

  // update strobe is the route stage accept
  llc_tag_store u_tag_store (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lookup_index_i (s1_index),
    .lookup_tag_i   (s1_tag),
    .lookup_write_i (s1_write),
    .update_i       (s2_accept),
    .init_done_o    (init_done_o),
    .hit_o          (lookup_hit),
    .way_o          (lookup_way),
    .evict_o        (lookup_evict),
    .evict_tag_o    (lookup_evict_tag)
  );

  llc_route_stage u_route (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .valid_i          (s1_valid),
    .id_i             (s1_id),
    .addr_i           (s1_addr),
    .write_i          (s1_write),
    .hit_i            (lookup_hit),
    .way_i            (lookup_way),
    .evict_i          (lookup_evict),
    .evict_tag_i      (lookup_evict_tag),
    .accept_o         (s2_accept),
    .query_index_o    (query_index),
    .query_way_o      (query_way),
    .locked_i         (locked),
    .lock_req_o       (lock_req),
    .desc_id_o        (desc_id_o),
    .desc_addr_o      (desc_addr_o),
    .desc_write_o     (desc_write_o),
    .desc_way_o       (desc_way_o),
    .desc_hit_o       (desc_hit_o),
    .desc_evict_o     (desc_evict_o),
    .desc_evict_tag_o (desc_evict_tag_o),
    .hit_valid_o      (hit_valid_o),
    .hit_ready_i      (hit_ready_i),
    .miss_valid_o     (miss_valid_o),
    .miss_ready_i     (miss_ready_i)
  );

  llc_lock_box #(
    .LockEntries (LockEntries)
  ) u_lock_box (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .query_index_i  (query_index),
    .query_way_i    (query_way),
    .lock_req_i     (lock_req),
    .unlock_valid_i (unlock_valid_i),
    .unlock_index_i (unlock_index_i),
    .unlock_way_i   (unlock_way_i),
    .locked_o       (locked)
  );

endmodule

//--- logic/llc_lock_box.sv
// Table of cache lines in use downstream of the LLC hit/miss stage.
// The route stage locks a line on each output transfer, and an unlock
// strobe frees it again. A query is answered combinationally.

`timescale 1ns/100ps

module llc_lock_box #(
  parameter int unsigned LockEntries = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  llc_hit_miss_pkg::index_t   query_index_i,
  input  llc_hit_miss_pkg::way_ind_t query_way_i,
  input  logic                       lock_req_i,
  input  logic                       unlock_valid_i,
  input  llc_hit_miss_pkg::index_t   unlock_index_i,
  input  llc_hit_miss_pkg::way_ind_t unlock_way_i,
  output logic                       locked_o
);

  localparam int unsigned EntryBits = (LockEntries > 1) ? $clog2(LockEntries) : 1;

  logic                       [LockEntries-1:0] valid_q;
  llc_hit_miss_pkg::index_t   index_q [LockEntries];
  llc_hit_miss_pkg::way_ind_t way_q   [LockEntries];

  logic [LockEntries-1:0] query_hit;
  logic [LockEntries-1:0] unlock_hit;
  logic [EntryBits-1:0]   free_idx;

  // compare query and unlock line against every entry
  always_comb begin
    for (int e = 0; e < LockEntries; e++) begin
      query_hit[e]  = valid_q[e] && (index_q[e] == query_index_i)
                      && (way_q[e] == query_way_i);
      unlock_hit[e] = valid_q[e] && (index_q[e] == unlock_index_i)
                      && (way_q[e] == unlock_way_i);
    end
  end

  // lowest free entry
  always_comb begin
    free_idx = '0;
    for (int e = LockEntries - 1; e >= 0; e--) begin
      if (!valid_q[e]) begin
        free_idx = EntryBits'(e);
      end
    end
  end

  // a full table blocks every line
  assign locked_o = (|query_hit) || (&valid_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      // unknown lines simply match nothing
      if (unlock_valid_i) begin
        valid_q <= valid_q & ~unlock_hit;
      end
      if (lock_req_i) begin
        valid_q[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lock_req_i) begin
      index_q[free_idx] <= query_index_i;
      way_q[free_idx]   <= query_way_i;
    end
  end

  // route stage only sends on an unlocked line
  lock_only_free : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) lock_req_i |-> !locked_o)
    else $error("lock request for a locked line");

endmodule

//--- logic/llc_route_stage.sv
// Second pipeline register of the LLC hit/miss stage.
// Captures a descriptor with its lookup result, waits while its line is
// locked downstream and then offers it on the hit or the miss port.
// Every output transfer locks the line in the lock box.

`timescale 1ns/100ps

module llc_route_stage (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // from the lookup stage and the tag store
  input  logic                       valid_i,
  input  llc_hit_miss_pkg::id_t      id_i,
  input  llc_hit_miss_pkg::addr_t    addr_i,
  input  logic                       write_i,
  input  logic                       hit_i,
  input  llc_hit_miss_pkg::way_ind_t way_i,
  input  logic                       evict_i,
  input  llc_hit_miss_pkg::tag_t     evict_tag_i,
  output logic                       accept_o,
  // lock box
  output llc_hit_miss_pkg::index_t   query_index_o,
  output llc_hit_miss_pkg::way_ind_t query_way_o,
  input  logic                       locked_i,
  output logic                       lock_req_o,
  // output ports
  output llc_hit_miss_pkg::id_t      desc_id_o,
  output llc_hit_miss_pkg::addr_t    desc_addr_o,
  output logic                       desc_write_o,
  output llc_hit_miss_pkg::way_ind_t desc_way_o,
  output logic                       desc_hit_o,
  output logic                       desc_evict_o,
  output llc_hit_miss_pkg::tag_t     desc_evict_tag_o,
  output logic                       hit_valid_o,
  input  logic                       hit_ready_i,
  output logic                       miss_valid_o,
  input  logic                       miss_ready_i
);

  logic busy_q;
  logic leave;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  // held item is offered only while its line is free
  assign hit_valid_o  = busy_q && !locked_i && desc_hit_o;
  assign miss_valid_o = busy_q && !locked_i && !desc_hit_o;
  assign leave        = (hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i);

  // also the tag store update strobe
  assign accept_o     = valid_i && (!busy_q || leave);
  assign lock_req_o   = leave;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (accept_o) begin
      busy_q <= 1'b1;
    end else if (leave) begin
      busy_q <= 1'b0;
    end
  end

  // descriptor with its lookup result
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      desc_id_o        <= id_i;
      desc_addr_o      <= addr_i;
      desc_write_o     <= write_i;
      desc_way_o       <= way_i;
      desc_hit_o       <= hit_i;
      desc_evict_o     <= evict_i;
      desc_evict_tag_o <= evict_tag_i;
    end
  end

  // line of the held item
  assign query_index_o = desc_addr_o[llc_hit_miss_pkg::OffsetBits +: llc_hit_miss_pkg::IndexBits];
  assign query_way_o   = desc_way_o;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  one_port_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(hit_valid_o && miss_valid_o))
    else $error("hit and miss valid together");

  // way comes from the tag store lookup one cycle earlier
  way_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (hit_valid_o || miss_valid_o) |-> $onehot(desc_way_o))
    else $error("output way is not one-hot");

endmodule

//--- logic/llc_lookup_stage.sv
// First pipeline register of the LLC hit/miss stage.
// Takes descriptors from the input channel once the tag store is cleared
// and presents the set index and tag of the held one to the tag store.

`timescale 1ns/100ps

module llc_lookup_stage (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  llc_hit_miss_pkg::id_t    id_i,
  input  llc_hit_miss_pkg::addr_t  addr_i,
  input  logic                     write_i,
  input  logic                     init_done_i,
  input  logic                     accept_i,
  output logic                     ready_o,
  output logic                     valid_o,
  output llc_hit_miss_pkg::id_t    id_o,
  output llc_hit_miss_pkg::addr_t  addr_o,
  output logic                     write_o,
  output llc_hit_miss_pkg::index_t index_o,
  output llc_hit_miss_pkg::tag_t   tag_o
);

  logic load;

  // free when empty or when the route stage takes the item this edge
  assign ready_o = init_done_i && (!valid_o || accept_i);
  assign load    = valid_i && ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (load) begin
      valid_o <= 1'b1;
    end else if (accept_i) begin
      valid_o <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      id_o    <= id_i;
      addr_o  <= addr_i;
      write_o <= write_i;
    end
  end

  // split the held address for the tag store
  assign index_o = addr_o[llc_hit_miss_pkg::OffsetBits +: llc_hit_miss_pkg::IndexBits];
  assign tag_o   = addr_o[llc_hit_miss_pkg::AddrWidth-1 -: llc_hit_miss_pkg::TagBits];

endmodule

//--- logic/llc_tag_store.sv
// Tag, valid and dirty storage of the LLC hit/miss stage.
// Clears itself one set per cycle after reset, then answers a lookup
// combinationally and writes the matching update on the accept strobe.

`timescale 1ns/100ps

module llc_tag_store (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  llc_hit_miss_pkg::index_t   lookup_index_i,
  input  llc_hit_miss_pkg::tag_t     lookup_tag_i,
  input  logic                       lookup_write_i,
  input  logic                       update_i,
  output logic                       init_done_o,
  output logic                       hit_o,
  output llc_hit_miss_pkg::way_ind_t way_o,
  output logic                       evict_o,
  output llc_hit_miss_pkg::tag_t     evict_tag_o
);

  typedef enum logic {
    init_clear,
    init_run
  } init_state_e;

  init_state_e                 state_q;
  llc_hit_miss_pkg::index_t    clr_idx_q;

  // storage swept clear after reset
  llc_hit_miss_pkg::tag_t      tag_q   [llc_hit_miss_pkg::NumSets][llc_hit_miss_pkg::NumWays];
  llc_hit_miss_pkg::way_ind_t  valid_q [llc_hit_miss_pkg::NumSets];
  llc_hit_miss_pkg::way_ind_t  dirty_q [llc_hit_miss_pkg::NumSets];
  llc_hit_miss_pkg::way_idx_t  rr_q    [llc_hit_miss_pkg::NumSets];

  llc_hit_miss_pkg::way_ind_t  match;
  llc_hit_miss_pkg::way_idx_t  hit_idx;
  llc_hit_miss_pkg::way_idx_t  vict_idx;
  logic                        all_valid;

  ////////////////////////////////////////////////////////////////////////////
  // clear sweep
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= init_clear;
      clr_idx_q <= '0;
    end else if (state_q == init_clear) begin
      clr_idx_q <= clr_idx_q + 1'b1;
      // last set cleared this cycle
      if (clr_idx_q == llc_hit_miss_pkg::index_t'(llc_hit_miss_pkg::NumSets - 1)) begin
        state_q <= init_run;
      end
    end
  end

  assign init_done_o = (state_q == init_run);

  ////////////////////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////////////////////

  // tag compare over all ways of the set
  always_comb begin
    hit_idx = '0;
    for (int w = 0; w < llc_hit_miss_pkg::NumWays; w++) begin
      match[w] = valid_q[lookup_index_i][w] && (tag_q[lookup_index_i][w] == lookup_tag_i);
      if (match[w]) begin
        hit_idx = llc_hit_miss_pkg::way_idx_t'(w);
      end
    end
  end

  // victim is the lowest invalid way, else the round-robin pointer
  always_comb begin
    all_valid = 1'b1;
    vict_idx  = rr_q[lookup_index_i];
    for (int w = llc_hit_miss_pkg::NumWays - 1; w >= 0; w--) begin
      if (!valid_q[lookup_index_i][w]) begin
        all_valid = 1'b0;
        vict_idx  = llc_hit_miss_pkg::way_idx_t'(w);
      end
    end
  end

  assign hit_o       = |match;
  assign way_o       = hit_o ? match : llc_hit_miss_pkg::way_ind_t'(1) << vict_idx;
  // only a valid and dirty victim needs a write back
  assign evict_o     = !hit_o && valid_q[lookup_index_i][vict_idx]
                       && dirty_q[lookup_index_i][vict_idx];
  assign evict_tag_o = tag_q[lookup_index_i][vict_idx];

  ////////////////////////////////////////////////////////////////////////////
  // update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == init_clear) begin
      valid_q[clr_idx_q] <= '0;
      dirty_q[clr_idx_q] <= '0;
      rr_q[clr_idx_q]    <= '0;
    end else if (update_i) begin
      if (hit_o) begin
        // a write to a hit line makes it dirty
        dirty_q[lookup_index_i][hit_idx] <= dirty_q[lookup_index_i][hit_idx] | lookup_write_i;
      end else begin
        tag_q[lookup_index_i][vict_idx]   <= lookup_tag_i;
        valid_q[lookup_index_i][vict_idx] <= 1'b1;
        dirty_q[lookup_index_i][vict_idx] <= lookup_write_i;
        // pointer moves only when it picked the victim
        if (all_valid) begin
          rr_q[lookup_index_i] <= rr_q[lookup_index_i] + 1'b1;
        end
      end
    end
  end

  // route stage must not take a descriptor during the sweep
  update_after_init : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) update_i |-> init_done_o)
    else $error("tag update during clear sweep");

endmodule

//--- logic/llc_hit_miss_pkg.sv
// Shared definitions for the LLC hit/miss stage.
// Holds the fixed cache geometry and the vector types that the stages use
// for addresses, ids, set indices, tags and way numbers.

package llc_hit_miss_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////////////////////////////////////////

  // descriptor address and id widths
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned IdWidth    = 4;

  // 64 byte lines
  localparam int unsigned OffsetBits = 6;

  // 16 sets of 4 ways
  localparam int unsigned NumSets    = 16;
  localparam int unsigned NumWays    = 4;
  localparam int unsigned IndexBits  = $clog2(NumSets);

  // tag is whatever is left above index and offset
  localparam int unsigned TagBits    = AddrWidth - IndexBits - OffsetBits;

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0]         addr_t;
  typedef logic [IdWidth-1:0]           id_t;

  // address bits 9:6
  typedef logic [IndexBits-1:0]         index_t;

  // address bits 31:10
  typedef logic [TagBits-1:0]           tag_t;

  // one-hot way, one bit per way
  typedef logic [NumWays-1:0]           way_ind_t;

  // binary way number
  typedef logic [$clog2(NumWays)-1:0]   way_idx_t;

endpackage
